/* hw/dcache_cfg.svh */
/*
 * geometry and address split of the 4-way data cache
 * include wherever a width or a field position is needed
 */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// ways are fixed at four, the tree plru and control word assume it
`define DCACHE_WAYS      4
`define DCACHE_SETS      256
`define DCACHE_SET_BITS  8

`define DCACHE_TAG_BITS  20
`define DCACHE_LINE_BITS 128   // 16 byte line

// byte address fields
`define DCACHE_TAG_LSB   12    // tag is 31..12
`define DCACHE_SET_LSB   4     // set is 11..4
`define DCACHE_WORD_LSB  2     // word in line is 3..2

`endif

/* hw/dcache_pkg.sv */
/*
 * packed types shared by the data cache blocks
 * referenced by scoped name from the rtl and the testbench
 */
`include "dcache_cfg.svh"

package dcache_pkg;

    // per-way state bits in the control word
    typedef struct packed {
        logic dirty;
        logic valid;
    } way_state_t;

    // one way entry of a set
    typedef struct packed {
        logic [`DCACHE_TAG_BITS-1:0]  tag;
        logic [`DCACHE_LINE_BITS-1:0] data;
    } way_line_t;

    // per-set control word, way 0 valid is bit 0
    typedef struct packed {
        logic                            plru_r;    // right pair, set means way 3 is older
        logic                            plru_l;    // left pair, set means way 1 is older
        logic                            plru_root; // set means right half is older
        way_state_t [`DCACHE_WAYS-1:0]   way;
    } set_ctrl_t;

    typedef struct packed {
        logic        write;
        logic [31:0] address;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        hit;       // served without memory traffic
    } cpu_resp_t;

    // request after address split
    typedef struct packed {
        logic                                        write;
        logic [`DCACHE_TAG_BITS-1:0]                 tag;
        logic [`DCACHE_SET_BITS-1:0]                 set;
        logic [`DCACHE_SET_LSB-`DCACHE_WORD_LSB-1:0] word;
        logic [31:0]                                 wdata;
    } lookup_t;

    typedef struct packed {
        logic                         matched;
        logic [1:0]                   matched_index;
        logic [`DCACHE_LINE_BITS-1:0] matched_data_line;
        logic [1:0]                   plru_index;       // victim way on a miss
        way_line_t                    plru_data_line;   // victim tag kept for writeback
        logic                         writeback_needed;
    } match_t;

    // control words to store for each kind of completion
    typedef struct packed {
        set_ctrl_t after_match;
        set_ctrl_t after_line_read;
        set_ctrl_t after_write_to_existing;
        set_ctrl_t after_write_to_new;
    } next_ctrl_t;

    typedef struct packed {
        logic [31-`DCACHE_SET_LSB:0]  address;   // line address
        logic [`DCACHE_LINE_BITS-1:0] data;
    } mem_line_t;

endpackage

/* hw/dcache_set_ram.sv */
/*
 * single-port set array with registered read
 * one instance per way for lines and one for the control words
 */
`include "dcache_cfg.svh"

module dcache_set_ram #(
    parameter type entry_t = logic [7:0]
) (
    input  logic                        clk,
    input  logic [`DCACHE_SET_BITS-1:0] address,
    input  logic                        wren,
    input  entry_t                      wrdata,
    output entry_t                      q
);

    entry_t mem [`DCACHE_SETS];   // one entry per set

    // read returns the old entry when written in the same cycle
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= wrdata;
        end
        q <= mem[address];
    end

endmodule

/* hw/dcache_way_match.sv */
/*
 * tag compare over the four ways of the addressed set
 * also picks the plru victim, flags a dirty victim and
 * prepares the control word for every way a request can finish
 */
`include "dcache_cfg.svh"

module dcache_way_match (
    input  logic [`DCACHE_TAG_BITS-1:0] tag,
    input  dcache_pkg::set_ctrl_t       control,
    input  dcache_pkg::way_line_t       line_0,
    input  dcache_pkg::way_line_t       line_1,
    input  dcache_pkg::way_line_t       line_2,
    input  dcache_pkg::way_line_t       line_3,
    output dcache_pkg::match_t          match,
    output dcache_pkg::next_ctrl_t      next_ctrl
);

    dcache_pkg::way_line_t lines [`DCACHE_WAYS];
    logic                  hit;
    logic [1:0]            hit_idx;
    logic [1:0]            victim;

    // record an access to way w in the plru tree
    function automatic dcache_pkg::set_ctrl_t touch(input dcache_pkg::set_ctrl_t c,
                                                    input logic [1:0] w);
        dcache_pkg::set_ctrl_t n;
        n = c;
        n.plru_root = ~w[1];   // point away from the used half
        if (w[1]) begin
            n.plru_r = ~w[0];
        end else begin
            n.plru_l = ~w[0];
        end
        return n;
    endfunction

    assign lines = '{line_0, line_1, line_2, line_3};

    // first valid way with an equal tag
    always_comb begin
        hit     = 1'b0;
        hit_idx = 2'd0;
        for (int i = `DCACHE_WAYS - 1; i >= 0; i--) begin   // walk down so way 0 wins
            if (control.way[i].valid && lines[i].tag == tag) begin
                hit     = 1'b1;
                hit_idx = 2'(i);
            end
        end
    end

    always_comb begin
        // tree walk when the set is full
        if (!control.plru_root) begin
            victim = control.plru_l ? 2'd1 : 2'd0;
        end else begin
            victim = control.plru_r ? 2'd3 : 2'd2;
        end
        // any empty way beats the tree, lowest first
        for (int i = `DCACHE_WAYS - 1; i >= 0; i--) begin
            if (!control.way[i].valid) begin
                victim = 2'(i);
            end
        end
    end

    always_comb begin
        match.matched           = hit;
        match.matched_index     = hit_idx;
        match.matched_data_line = lines[hit_idx].data;
        match.plru_index        = victim;
        match.plru_data_line    = lines[victim];
        // only a valid dirty victim has to go back
        match.writeback_needed  = control.way[victim].valid & control.way[victim].dirty;
    end

    always_comb begin
        next_ctrl.after_match = touch(control, hit_idx);   // read hit

        next_ctrl.after_write_to_existing = next_ctrl.after_match;
        next_ctrl.after_write_to_existing.way[hit_idx].dirty = 1'b1;

        // fill replaces the victim, the old dirty bit went out with the writeback
        next_ctrl.after_line_read = touch(control, victim);
        next_ctrl.after_line_read.way[victim] = '{dirty: 1'b0, valid: 1'b1};

        next_ctrl.after_write_to_new = touch(control, victim);   // write miss allocates dirty
        next_ctrl.after_write_to_new.way[victim] = '{dirty: 1'b1, valid: 1'b1};
    end

endmodule

/* hw/dcache_req_decode.sv */
/*
 * request stage of the data cache
 * captures an accepted processor request and splits its address
 * lk stays stable until the next accepted request
 */
`include "dcache_cfg.svh"

module dcache_req_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  dcache_pkg::cpu_req_t  req,
    input  logic                  accept,     // controller is free
    output dcache_pkg::lookup_t   lk,
    output logic                  lk_valid
);

    logic take;

    assign take = req_valid & accept;   // pulses while busy are dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk_valid <= 1'b0;
        end else begin
            lk_valid <= take;   // one cycle pulse per request
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            lk.write <= req.write;
            lk.tag   <= req.address[31:`DCACHE_TAG_LSB];
            lk.set   <= req.address[`DCACHE_TAG_LSB-1:`DCACHE_SET_LSB];
            lk.word  <= req.address[`DCACHE_SET_LSB-1:`DCACHE_WORD_LSB];
            lk.wdata <= req.wdata;
        end
    end

endmodule

/* hw/dcache_ctrl.sv */
/*
 * execute and result stage of the data cache
 * sweeps the control array after reset, then runs lookup,
 * writeback and fill for one request at a time and returns the response
 */
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  dcache_pkg::lookup_t           lk,
    input  logic                          lk_valid,
    input  dcache_pkg::match_t            match,
    input  dcache_pkg::next_ctrl_t        next_ctrl,
    output logic                          accept,
    output logic                          busy,
    output logic                          done,
    output dcache_pkg::cpu_resp_t         resp,
    output logic [`DCACHE_SET_BITS-1:0]   ram_address,
    output logic [`DCACHE_WAYS-1:0]       way_wren,
    output dcache_pkg::way_line_t         way_wrdata,
    output logic                          ctrl_wren,
    output dcache_pkg::set_ctrl_t         ctrl_wrdata,
    output logic                          mem_read_do,
    output logic [31-`DCACHE_SET_LSB:0]   mem_read_address,
    input  logic                          mem_read_done,
    input  logic [`DCACHE_LINE_BITS-1:0]  mem_read_data,
    output logic                          mem_write_do,
    output dcache_pkg::mem_line_t         mem_write,
    input  logic                          mem_write_done
);

    typedef enum logic [2:0] {
        S_INIT,        // clearing control words
        S_IDLE,
        S_LOOKUP,      // array data valid, matcher result used here
        S_WRITEBACK,
        S_FILL
    } state_t;

    state_t                        state;
    logic [`DCACHE_SET_BITS-1:0]   init_cnt;
    logic [`DCACHE_LINE_BITS-1:0]  src_line;   // hit line or line from memory
    logic [`DCACHE_LINE_BITS-1:0]  new_line;   // src_line with the write merged in
    logic [31:0]                   rd_word;
    logic                          finish;     // request completes at this edge

    assign accept = (state == S_IDLE) && !lk_valid;
    assign busy   = !accept;   // also high through the sweep

    assign ram_address = (state == S_INIT) ? init_cnt : lk.set;

    assign mem_read_address = {lk.tag, lk.set};
    // victim goes back to its own line address
    assign mem_write.address = {match.plru_data_line.tag, lk.set};
    assign mem_write.data    = match.plru_data_line.data;

    assign src_line = (state == S_FILL) ? mem_read_data : match.matched_data_line;
    assign rd_word  = src_line[lk.word*32 +: 32];

    always_comb begin
        new_line = src_line;
        if (lk.write) begin
            new_line[lk.word*32 +: 32] = lk.wdata;
        end
    end

    assign finish = (state == S_LOOKUP && match.matched) ||
                    (state == S_FILL && mem_read_done);

    // array write port
    always_comb begin
        way_wren        = '0;
        way_wrdata.tag  = lk.tag;
        way_wrdata.data = new_line;
        ctrl_wren       = 1'b0;
        ctrl_wrdata     = next_ctrl.after_match;
        case (state)
            S_INIT: begin
                ctrl_wren   = 1'b1;
                ctrl_wrdata = '0;   // all ways invalid
            end
            S_LOOKUP: begin
                if (match.matched) begin
                    ctrl_wren = 1'b1;   // plru moves on read hits too
                    if (lk.write) begin
                        way_wren[match.matched_index] = 1'b1;
                        ctrl_wrdata = next_ctrl.after_write_to_existing;
                    end
                end
            end
            S_FILL: begin
                if (mem_read_done) begin
                    way_wren[match.plru_index] = 1'b1;
                    ctrl_wren   = 1'b1;
                    ctrl_wrdata = lk.write ? next_ctrl.after_write_to_new
                                           : next_ctrl.after_line_read;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_INIT;
            init_cnt     <= '0;
            done         <= 1'b0;
            mem_read_do  <= 1'b0;
            mem_write_do <= 1'b0;
        end else begin
            done         <= finish;
            mem_read_do  <= 1'b0;   // both are single cycle pulses
            mem_write_do <= 1'b0;
            case (state)
                S_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == `DCACHE_SETS - 1) begin
                        state <= S_IDLE;
                    end
                end
                S_IDLE: begin
                    if (lk_valid) begin
                        state <= S_LOOKUP;   // arrays read at this edge
                    end
                end
                S_LOOKUP: begin
                    if (match.matched) begin
                        state <= S_IDLE;
                    end else if (match.writeback_needed) begin
                        state        <= S_WRITEBACK;
                        mem_write_do <= 1'b1;
                    end else begin
                        state       <= S_FILL;
                        mem_read_do <= 1'b1;
                    end
                end
                S_WRITEBACK: begin
                    if (mem_write_done) begin   // fetch only after the victim is out
                        state       <= S_FILL;
                        mem_read_do <= 1'b1;
                    end
                end
                S_FILL: begin
                    if (mem_read_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_INIT;
            endcase
        end
    end

    // response holds until the next done
    always_ff @(posedge clk) begin
        if (finish) begin
            resp.rdata <= rd_word;   // on a write this is the word before the merge
            resp.hit   <= (state == S_LOOKUP);
        end
    end

endmodule

/* hw/dcache_top.sv */
/*
 * data cache top level
 * 4-way set associative, write-back, one request at a time
 * connects decode, the set arrays, the matcher and the controller
 */
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  dcache_pkg::cpu_req_t          req,
    output logic                          busy,
    output logic                          done,
    output dcache_pkg::cpu_resp_t         resp,
    output logic                          mem_read_do,
    output logic [31-`DCACHE_SET_LSB:0]   mem_read_address,
    input  logic                          mem_read_done,
    input  logic [`DCACHE_LINE_BITS-1:0]  mem_read_data,
    output logic                          mem_write_do,
    output dcache_pkg::mem_line_t         mem_write,
    input  logic                          mem_write_done
);

    dcache_pkg::lookup_t          lk;
    logic                         lk_valid;
    logic                         accept;
    dcache_pkg::match_t           match;
    dcache_pkg::next_ctrl_t       next_ctrl;
    logic [`DCACHE_SET_BITS-1:0]  ram_address;
    logic [`DCACHE_WAYS-1:0]      way_wren;
    dcache_pkg::way_line_t        way_wrdata;
    dcache_pkg::way_line_t        way_q [`DCACHE_WAYS];
    logic                         ctrl_wren;
    dcache_pkg::set_ctrl_t        ctrl_wrdata;
    dcache_pkg::set_ctrl_t        ctrl_q;

    dcache_req_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .accept    (accept),
        .lk        (lk),
        .lk_valid  (lk_valid)
    );

    // one line array per way, all share address and write data
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_set_ram #(.entry_t(dcache_pkg::way_line_t)) u_way_ram (
            .clk     (clk),
            .address (ram_address),
            .wren    (way_wren[w]),
            .wrdata  (way_wrdata),
            .q       (way_q[w])
        );
    end

    dcache_set_ram #(.entry_t(dcache_pkg::set_ctrl_t)) u_ctrl_ram (
        .clk     (clk),
        .address (ram_address),
        .wren    (ctrl_wren),
        .wrdata  (ctrl_wrdata),
        .q       (ctrl_q)
    );

    dcache_way_match u_match (
        .tag       (lk.tag),
        .control   (ctrl_q),
        .line_0    (way_q[0]),
        .line_1    (way_q[1]),
        .line_2    (way_q[2]),
        .line_3    (way_q[3]),
        .match     (match),
        .next_ctrl (next_ctrl)
    );

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .lk               (lk),
        .lk_valid         (lk_valid),
        .match            (match),
        .next_ctrl        (next_ctrl),
        .accept           (accept),
        .busy             (busy),
        .done             (done),
        .resp             (resp),
        .ram_address      (ram_address),
        .way_wren         (way_wren),
        .way_wrdata       (way_wrdata),
        .ctrl_wren        (ctrl_wren),
        .ctrl_wrdata      (ctrl_wrdata),
        .mem_read_do      (mem_read_do),
        .mem_read_address (mem_read_address),
        .mem_read_done    (mem_read_done),
        .mem_read_data    (mem_read_data),
        .mem_write_do     (mem_write_do),
        .mem_write        (mem_write),
        .mem_write_done   (mem_write_done)
    );

endmodule

/* tests/tb_mem_model.sv */
/*
 * backing memory for the data cache testbench
 * 64K words filled from their address, answers a line read
 * or a line write with a done pulse 4 cycles after the request pulse
 */
`include "dcache_cfg.svh"

module tb_mem_model (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          read_do,
    input  logic [31-`DCACHE_SET_LSB:0]   read_address,
    output logic                          read_done,
    output logic [`DCACHE_LINE_BITS-1:0]  read_data,
    input  logic                          write_do,
    input  dcache_pkg::mem_line_t         write,
    output logic                          write_done
);

    localparam int DELAY = 4;   // cycles from request pulse to done

    logic [31:0] words [65536];   // word addressed, byte address bits 17..2
    logic [13:0] read_line;       // line index of the pending read
    int          read_wait;
    int          write_wait;

    // every word differs, pattern uses all index bits
    initial begin
        for (int i = 0; i < 65536; i++) begin
            words[i] = {16'(i) ^ 16'hC3A5, ~8'(i), 8'(i >> 8)};
        end
    end

    // line write lands at once, the done pulse comes later
    always @(posedge clk) begin
        if (write_do) begin
            for (int k = 0; k < 4; k++) begin
                words[{write.address[13:0], 2'(k)}] <= write.data[k*32 +: 32];
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_done  <= 1'b0;
            write_done <= 1'b0;
            read_wait  <= 0;
            write_wait <= 0;
            read_line  <= '0;
            read_data  <= '0;
        end else begin
            read_done  <= 1'b0;   // pulses
            write_done <= 1'b0;
            if (read_do) begin
                read_wait <= DELAY;
                read_line <= read_address[13:0];   // upper tag bits fold away
            end else if (read_wait == 1) begin
                read_wait <= 0;
                read_done <= 1'b1;
                read_data <= {words[{read_line, 2'd3}], words[{read_line, 2'd2}],
                              words[{read_line, 2'd1}], words[{read_line, 2'd0}]};
            end else if (read_wait > 1) begin
                read_wait <= read_wait - 1;
            end
            if (write_do) begin
                write_wait <= DELAY;
            end else if (write_wait == 1) begin
                write_wait <= 0;
                write_done <= 1'b1;
            end else if (write_wait > 1) begin
                write_wait <= write_wait - 1;
            end
        end
    end

endmodule

/* tests/tb_dcache.sv */
/*
 * directed testbench for the data cache
 * drives word reads and writes through the memory model and checks
 * data, hit flag, hit latency, plru victim choice and writebacks
 */
`include "dcache_cfg.svh"

module tb_dcache;

    localparam int TIMEOUT = 2000;   // cycles allowed for any single wait

    logic                          clk;
    logic                          rst_n;
    logic                          req_valid;
    dcache_pkg::cpu_req_t          req;
    logic                          busy;
    logic                          done;
    dcache_pkg::cpu_resp_t         resp;
    logic                          mem_read_do;
    logic [31-`DCACHE_SET_LSB:0]   mem_read_address;
    logic                          mem_read_done;
    logic [`DCACHE_LINE_BITS-1:0]  mem_read_data;
    logic                          mem_write_do;
    dcache_pkg::mem_line_t         mem_write;
    logic                          mem_write_done;

    logic [31:0]                   shadow [int];         // written words by word index
    int                            read_count = 0;       // mem_read_do pulses seen
    int                            write_count = 0;
    int                            reads_at_write = 0;   // read_count when the last writeback left
    logic [31-`DCACHE_SET_LSB:0]   last_read_address;    // line address of the last fill
    dcache_pkg::mem_line_t         last_write;
    int                            seed;

    dcache_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .req              (req),
        .busy             (busy),
        .done             (done),
        .resp             (resp),
        .mem_read_do      (mem_read_do),
        .mem_read_address (mem_read_address),
        .mem_read_done    (mem_read_done),
        .mem_read_data    (mem_read_data),
        .mem_write_do     (mem_write_do),
        .mem_write        (mem_write),
        .mem_write_done   (mem_write_done)
    );

    tb_mem_model u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_do      (mem_read_do),
        .read_address (mem_read_address),
        .read_done    (mem_read_done),
        .read_data    (mem_read_data),
        .write_do     (mem_write_do),
        .write        (mem_write),
        .write_done   (mem_write_done)
    );

    always #5 clk = ~clk;

    // memory traffic, sampled on the falling edge where it is stable
    always @(negedge clk) begin
        if (mem_read_do) begin
            read_count++;
            last_read_address = mem_read_address;
        end
        if (mem_write_do) begin
            write_count++;
            last_write     = mem_write;
            reads_at_write = read_count;
        end
    end

    // current memory word, the shadow copy if written, else the fill pattern
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [15:0] idx;
        idx = addr[17:2];
        if (shadow.exists(int'(idx))) begin
            return shadow[int'(idx)];
        end
        return {idx ^ 16'hC3A5, ~idx[7:0], idx[15:8]};
    endfunction

    function automatic logic [31:0] addr_of(input int tag, input int set, input int word);
        return 32'((tag << 12) | (set << 4) | (word << 2));
    endfunction

    // whole line as memory should hold it, word 0 in the low bits
    function automatic dcache_pkg::mem_line_t line_of(input logic [31:0] addr);
        dcache_pkg::mem_line_t l;
        l.address = addr[31:4];
        for (int k = 0; k < 4; k++) begin
            l.data[k*32 +: 32] = model_word({addr[31:4], 4'h0} + 32'(k * 4));
        end
        return l;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_resp(input string name, input dcache_pkg::cpu_resp_t got,
                              input dcache_pkg::cpu_resp_t exp, input bit with_hit);
        if (got.rdata !== exp.rdata || (with_hit && got.hit !== exp.hit)) begin
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_mem_line(input string name, input dcache_pkg::mem_line_t got,
                                  input dcache_pkg::mem_line_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                abort_run("timeout: the cache stayed busy and took no request");
            end
        end
    endtask

    // one request, cycle is the cycle of done counted from the accepting edge
    task automatic cache_access(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wd, output dcache_pkg::cpu_resp_t r,
                                output int cycle);
        wait_idle();
        req_valid   = 1'b1;
        req.write   = wr;
        req.address = addr;
        req.wdata   = wd;
        @(posedge clk);   // accepting edge
        #1;
        req_valid = 1'b0;
        cycle     = 1;
        while (!done) begin
            @(posedge clk);
            #1;
            cycle++;
            if (cycle > TIMEOUT) begin
                abort_run("timeout: no done after an accepted request");
            end
        end
        r = resp;
        if (wr) begin
            shadow[int'(addr[17:2])] = wd;
        end
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic hit, input bit with_hit);
        dcache_pkg::cpu_resp_t r;
        dcache_pkg::cpu_resp_t exp;
        int                    cycle;
        exp.rdata = model_word(addr);
        exp.hit   = hit;
        cache_access(1'b0, addr, 32'h0, r, cycle);
        check_resp("resp", r, exp, with_hit);
    endtask

    task automatic test_read_miss();
        int          reads;
        logic [31:0] addr;
        addr = addr_of(3, 1, 2);
        check_count("busy after reset", int'(busy), 1);   // sweep running
        reads = read_count;
        read_expect(addr, 1'b0, 1'b1);
        check_count("mem_read_do pulses", read_count - reads, 1);
        check_count("mem_read_address", int'(last_read_address), int'(addr[31:4]));
    endtask

    task automatic test_read_hit();
        dcache_pkg::cpu_resp_t r;
        dcache_pkg::cpu_resp_t exp;
        int                    cycle;
        int                    traffic;
        traffic   = read_count + write_count;
        exp.rdata = model_word(addr_of(3, 1, 1));
        exp.hit   = 1'b1;
        cache_access(1'b0, addr_of(3, 1, 1), 32'h0, r, cycle);   // other word, same line
        check_resp("resp", r, exp, 1'b1);
        check_count("hit done cycle", cycle, 3);
        check_count("mem traffic on hit", read_count + write_count - traffic, 0);
    endtask

    task automatic test_write();
        dcache_pkg::cpu_resp_t r;
        int                    cycle;
        int                    reads;
        cache_access(1'b1, addr_of(3, 1, 0), 32'hDEAD_BEEF, r, cycle);   // write hit
        read_expect(addr_of(3, 1, 0), 1'b1, 1'b1);
        reads = read_count;
        cache_access(1'b1, addr_of(9, 3, 1), 32'h0BAD_F00D, r, cycle);   // write miss allocates
        check_count("mem_read_do on write miss", read_count - reads, 1);
        read_expect(addr_of(9, 3, 1), 1'b1, 1'b1);
        read_expect(addr_of(9, 3, 3), 1'b1, 1'b1);   // rest of the line from memory
    endtask

    task automatic test_plru();
        int writes;
        writes = write_count;
        for (int t = 1; t <= 4; t++) begin
            read_expect(addr_of(t, 5, 0), 1'b0, 1'b1);   // empty ways fill 0..3 in order
        end
        read_expect(addr_of(1, 5, 0), 1'b1, 1'b1);   // way 0 again, root now points right
        read_expect(addr_of(5, 5, 0), 1'b0, 1'b1);   // plru_r clear so way 2 (tag 3) goes
        read_expect(addr_of(1, 5, 0), 1'b1, 1'b1);
        read_expect(addr_of(2, 5, 0), 1'b1, 1'b1);
        read_expect(addr_of(4, 5, 0), 1'b1, 1'b1);
        read_expect(addr_of(5, 5, 0), 1'b1, 1'b1);
        read_expect(addr_of(3, 5, 0), 1'b0, 1'b1);   // the victim
        check_count("mem_write_do on clean set", write_count - writes, 0);
    endtask

    task automatic test_writeback();
        dcache_pkg::cpu_resp_t r;
        dcache_pkg::mem_line_t exp_line;
        int                    cycle;
        int                    reads;
        int                    writes;
        writes = write_count;
        cache_access(1'b1, addr_of(1, 6, 2), 32'hCAFE_0001, r, cycle);   // way 0 dirty
        for (int t = 2; t <= 4; t++) begin
            read_expect(addr_of(t, 6, 0), 1'b0, 1'b1);
        end
        check_count("mem_write_do before eviction", write_count - writes, 0);
        // root and plru_l both clear now, so dirty way 0 is the victim
        exp_line = line_of(addr_of(1, 6, 0));
        reads    = read_count;
        read_expect(addr_of(5, 6, 0), 1'b0, 1'b1);
        check_count("mem_write_do on dirty eviction", write_count - writes, 1);
        check_mem_line("mem_write", last_write, exp_line);
        check_count("fills before writeback", reads_at_write - reads, 0);
        check_count("mem_read_do on dirty eviction", read_count - reads, 1);
        writes = write_count;
        read_expect(addr_of(6, 6, 0), 1'b0, 1'b1);   // every way clean now
        check_count("mem_write_do on clean eviction", write_count - writes, 0);
    endtask

    task automatic test_random();
        dcache_pkg::cpu_resp_t r;
        logic [31:0]           addr;
        int                    rnd;
        int                    cycle;
        for (int i = 0; i < 200; i++) begin
            rnd         = $random(seed);
            addr        = 32'h0;
            addr[14:12] = rnd[2:0];   // 8 tags over 4 sets forces evictions
            addr[5:4]   = rnd[4:3];
            addr[3:2]   = rnd[6:5];
            if (rnd[7]) begin
                cache_access(1'b1, addr, $random(seed), r, cycle);
            end else begin
                read_expect(addr, 1'b0, 1'b0);   // hit flag unknown here
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        seed      = 7;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_read_miss();
        test_read_hit();
        test_write();
        test_plru();
        test_writeback();
        test_random();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_set_ram.sv
hw/dcache_way_match.sv
hw/dcache_req_decode.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

/* Makefile */
# Verilator build and run of the data cache testbench
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TB PASSED

.PHONY: sim clean

# the simulator status is ignored, the log search decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
